// ==== source/booth_pkg.sv ====
package booth_pkg;

   // Each radix-8 digit retires three multiplier bits and overlaps the
   // previous group by one bit
   localparam int DIGIT_BITS = 3;

   // Bit positions inside one digit's select word
   localparam int SEL_SINGLE = 0;
   localparam int SEL_DOUBLE = 1;
   localparam int SEL_TRIPLE = 2;
   localparam int SEL_QUAD   = 3;
   localparam int SEL_NEG    = 4;

   // One recoded digit as magnitude one-hot plus sign
   // At most one of single, double, triple and quad is set
   // A digit of zero has no magnitude bit and may still carry neg
   typedef logic [4:0] booth_sel_t;

endpackage

// ==== source/booth_if.sv ====
// Stage 1 register outputs travelling from the recoder to the
// partial product generator
interface booth_if #(
   parameter int WIDTH  = 16,
   parameter int GROUPS = 6
);

   // One select word per Booth digit, digit 0 is the least significant
   booth_pkg::booth_sel_t [GROUPS-1:0] sel;

   // Multiplicand and its precomputed triple
   logic [WIDTH-1:0] mcand;
   logic [WIDTH+1:0] mcand3;

   // High for one cycle when the fields above hold a new operand pair
   logic valid;

   modport producer (
      output sel,
      output mcand,
      output mcand3,
      output valid
   );

   modport consumer (
      input sel,
      input mcand,
      input mcand3,
      input valid
   );

endinterface

// ==== source/booth_recoder.sv ====
module booth_recoder import booth_pkg::*; #(
   parameter int WIDTH  = 16,
   parameter int GROUPS = 6
) (
   input  logic             CLK,
   input  logic             rst_n,
   input  logic             in_valid,
   input  logic [WIDTH-1:0] multiplier,
   input  logic [WIDTH-1:0] multiplicand,
   booth_if.producer        bus
);

   // Multiplier with the implicit zero below bit 0 and zero fill above the MSB
   localparam int EXT_W = DIGIT_BITS * GROUPS + 1;

   typedef logic [WIDTH+1:0] triple_t;

   logic [EXT_W-1:0]          ext;
   booth_sel_t [GROUPS-1:0]   sel_d;
   triple_t                   triple_d;

   // Window bits are {b3, b2, b1, b0}, digit value is -4*b3 + 2*b2 + b1 + b0
   function automatic booth_sel_t encode(input logic [DIGIT_BITS:0] win);
      booth_sel_t s;
      logic       w0;
      logic       w1;
      logic       w2;
      w0 = win[0] ^ win[1];
      w1 = win[1] ^ win[2];
      w2 = win[2] ^ win[3];
      s = '0;
      s[SEL_NEG]    = win[3];
      s[SEL_SINGLE] = w0 & ~w2;
      s[SEL_DOUBLE] = w1 & ~w0;
      s[SEL_TRIPLE] = w2 & w0;
      s[SEL_QUAD]   = w2 & ~w0 & ~w1;
      return s;
   endfunction

   // The top window always sees a zero sign bit, so an unsigned
   // multiplier never ends on a negative digit
   assign ext = {{(EXT_W-WIDTH-1){1'b0}}, multiplier, 1'b0};

   for (genvar g = 0; g < GROUPS; g++) begin : g_digit
      assign sel_d[g] = encode(ext[DIGIT_BITS*g +: DIGIT_BITS+1]);
   end

   // 3M is the only hard multiple, M and 2M and 4M are plain shifts
   assign triple_d = {2'b00, multiplicand} + {1'b0, multiplicand, 1'b0};

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         bus.valid <= 1'b0;
      end else begin
         bus.valid <= in_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (in_valid) begin
         bus.sel    <= sel_d;
         bus.mcand  <= multiplicand;
         bus.mcand3 <= triple_d;
      end
   end

endmodule

// ==== source/pp_gen.sv ====
module pp_gen import booth_pkg::*; #(
   parameter int WIDTH  = 16,
   parameter int GROUPS = 6,
   parameter int ROWS   = 7
) (
   booth_if.consumer                    bus,
   output logic [ROWS-1:0][2*WIDTH-1:0] rows,
   output logic                         row_valid
);

   // Magnitude field of one partial product, wide enough for 4M
   localparam int PP_W = WIDTH + 2;

   typedef logic [2*WIDTH-1:0] row_t;
   typedef logic [PP_W-1:0]    pp_t;

   // Each row is treated as signed with its sign at bit PP_W. Storing the
   // inverted sign there adds 2^PP_W per row, which this constant takes back
   function automatic row_t sext_corr();
      row_t acc;
      row_t one;
      acc = '0;
      one = row_t'(1);
      for (int g = 0; g < GROUPS; g++) begin
         acc = acc + (one << (PP_W + DIGIT_BITS * g));
      end
      return ~acc + one;
   endfunction

   localparam row_t SEXT_CORR = sext_corr();

   pp_t  m1;
   pp_t  m2;
   pp_t  m4;
   row_t neg_row;

   assign m1 = {2'b00, bus.mcand};
   assign m2 = {1'b0, bus.mcand, 1'b0};
   assign m4 = {bus.mcand, 2'b00};

   for (genvar g = 0; g < GROUPS; g++) begin : g_row
      booth_sel_t s;
      pp_t        pick;
      pp_t        pp;

      assign s = bus.sel[g];

      // No select bit set gives zero
      assign pick = ({PP_W{s[SEL_SINGLE]}} & m1)
                  | ({PP_W{s[SEL_DOUBLE]}} & m2)
                  | ({PP_W{s[SEL_TRIPLE]}} & bus.mcand3)
                  | ({PP_W{s[SEL_QUAD]}}   & m4);

      // One's complement here, the +1 arrives through the correction row
      assign pp = pick ^ {PP_W{s[SEL_NEG]}};

      // Bits pushed past the product width drop out modulo 2^(2*WIDTH)
      assign rows[g] = row_t'({~s[SEL_NEG], pp}) << (DIGIT_BITS * g);
   end

   // The neg bits sit at most at bit WIDTH, below the lowest constant bit,
   // so they can simply be merged into the constant
   always_comb begin
      neg_row = '0;
      for (int g = 0; g < GROUPS; g++) begin
         neg_row[DIGIT_BITS*g] = bus.sel[g][SEL_NEG];
      end
   end

   assign rows[ROWS-1] = SEXT_CORR | neg_row;

   assign row_valid = bus.valid;

endmodule

// ==== source/csa_tree.sv ====
module csa_tree #(
   parameter int WIDTH = 16,
   parameter int ROWS  = 7
) (
   input  logic [ROWS-1:0][2*WIDTH-1:0] rows,
   input  logic                         row_valid,
   output logic [2*WIDTH-1:0]           sum,
   output logic [2*WIDTH-1:0]           carry,
   output logic                         red_valid
);

   typedef logic [2*WIDTH-1:0] row_t;

   // Rows left after a number of layers, each full triple becomes two rows
   function automatic int rows_after(input int layers);
      int n;
      n = ROWS;
      for (int l = 0; l < layers; l++) begin
         n = 2 * (n / 3) + n % 3;
      end
      return n;
   endfunction

   function automatic int layer_count();
      int n;
      int l;
      n = ROWS;
      l = 0;
      while (n > 2) begin
         n = 2 * (n / 3) + n % 3;
         l++;
      end
      return l;
   endfunction

   localparam int LAYERS = layer_count();

   // Entry [l][r] is row r entering layer l, slots past the live count are zero
   row_t lvl [LAYERS+1][ROWS];

   for (genvar r = 0; r < ROWS; r++) begin : g_in
      assign lvl[0][r] = rows[r];
   end

   for (genvar l = 0; l < LAYERS; l++) begin : g_layer
      localparam int N_IN  = rows_after(l);
      localparam int N_FA  = N_IN / 3;
      localparam int N_OUT = rows_after(l + 1);

      for (genvar g = 0; g < N_FA; g++) begin : g_fa
         row_t a;
         row_t b;
         row_t c;
         row_t maj;

         assign a   = lvl[l][3*g];
         assign b   = lvl[l][3*g+1];
         assign c   = lvl[l][3*g+2];
         assign maj = (a & b) | (a & c) | (b & c);

         // The carry out of the top column is beyond the product and is dropped
         assign lvl[l+1][2*g]   = a ^ b ^ c;
         assign lvl[l+1][2*g+1] = {maj[2*WIDTH-2:0], 1'b0};
      end

      // One or two rows that do not fill a compressor move on unchanged
      for (genvar r = 0; r < N_IN - 3 * N_FA; r++) begin : g_pass
         assign lvl[l+1][2*N_FA+r] = lvl[l][3*N_FA+r];
      end

      for (genvar r = N_OUT; r < ROWS; r++) begin : g_idle
         assign lvl[l+1][r] = '0;
      end
   end

   assign sum       = lvl[LAYERS][0];
   assign carry     = lvl[LAYERS][1];
   assign red_valid = row_valid;

endmodule

// ==== source/prefix_adder.sv ====
module prefix_adder #(
   parameter int WIDTH = 16
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic [2*WIDTH-1:0] sum,
   input  logic [2*WIDTH-1:0] carry,
   input  logic               red_valid,
   output logic [2*WIDTH-1:0] product,
   output logic               out_valid
);

   localparam int N      = 2 * WIDTH;
   localparam int LEVELS = $clog2(N);

   typedef logic [N-1:0] dword_t;

   dword_t gen;
   dword_t prop;
   dword_t grp_gen;
   dword_t grp_prop;
   dword_t total;

   assign gen  = sum & carry;
   assign prop = sum ^ carry;

   // Kogge-Stone style tree. At level lv every bit merges with the group
   // ending 2^lv bits below it, so after LEVELS steps grp_gen[i] is the
   // carry out of bits [i:0]
   always_comb begin
      grp_gen  = gen;
      grp_prop = prop;
      for (int lv = 0; lv < LEVELS; lv++) begin
         // High half generates, or high half propagates a low half generate
         grp_gen  = grp_gen | (grp_prop & (grp_gen << (1 << lv)));
         grp_prop = grp_prop & (grp_prop << (1 << lv));
      end
   end

   // Carry into bit i is the group generate of bits [i-1:0], bit 0 has none
   assign total = prop ^ {grp_gen[N-2:0], 1'b0};

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= red_valid;
      end
   end

   // Product holds between results
   always_ff @(posedge CLK) begin
      if (red_valid) begin
         product <= total;
      end
   end

endmodule

// ==== source/booth_mult_top.sv ====
module booth_mult_top import booth_pkg::*; #(
   parameter int WIDTH = 16
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               in_valid,
   input  logic [WIDTH-1:0]   multiplier,
   input  logic [WIDTH-1:0]   multiplicand,
   output logic               out_valid,
   output logic [2*WIDTH-1:0] product
);

   // Digits needed to cover the multiplier plus one zero bit on top
   localparam int GROUPS = (WIDTH + DIGIT_BITS) / DIGIT_BITS;
   // One row per digit and the correction row
   localparam int ROWS   = GROUPS + 1;

   logic [ROWS-1:0][2*WIDTH-1:0] rows;
   logic                         row_valid;
   logic [2*WIDTH-1:0]           sum;
   logic [2*WIDTH-1:0]           carry;
   logic                         red_valid;

   booth_if #(.WIDTH(WIDTH), .GROUPS(GROUPS)) stage1_bus ();

   booth_recoder #(.WIDTH(WIDTH), .GROUPS(GROUPS)) u_booth_recoder (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .multiplier   (multiplier),
      .multiplicand (multiplicand),
      .bus          (stage1_bus.producer)
   );

   pp_gen #(.WIDTH(WIDTH), .GROUPS(GROUPS), .ROWS(ROWS)) u_pp_gen (
      .bus       (stage1_bus.consumer),
      .rows      (rows),
      .row_valid (row_valid)
   );

   csa_tree #(.WIDTH(WIDTH), .ROWS(ROWS)) u_csa_tree (
      .rows      (rows),
      .row_valid (row_valid),
      .sum       (sum),
      .carry     (carry),
      .red_valid (red_valid)
   );

   prefix_adder #(.WIDTH(WIDTH)) u_prefix_adder (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .sum       (sum),
      .carry     (carry),
      .red_valid (red_valid),
      .product   (product),
      .out_valid (out_valid)
   );

endmodule

// ==== test/tb_booth_mult.sv ====
module tb_booth_mult;

   localparam int WIDTH      = 16;
   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 16;
   localparam int LATENCY    = 2;
   localparam int N_DIR      = 24;
   localparam int N_B2B      = 200;
   localparam int N_GAP      = 60;
   localparam int MAX_GAP    = 3;
   localparam int N_PRE_RST  = 12;
   localparam int N_POST_RST = 20;
   localparam int IDLE_START = 8;

   // Every gapped vector costs at most MAX_GAP idle cycles on top of its strobe
   localparam int TEST_CYCLES = 2 * RST_CYCLES + IDLE_START + N_DIR + N_B2B
                              + (MAX_GAP + 1) * N_GAP + N_PRE_RST + N_POST_RST;
   localparam int WATCH_CYCLES = TEST_CYCLES + 40 + 4 * 8;

   typedef logic [2*WIDTH-1:0] product_t;
   typedef logic [WIDTH-1:0]   operand_t;

   logic     CLK;
   logic     rst_n;
   logic     in_valid;
   operand_t multiplier;
   operand_t multiplicand;
   logic     out_valid;
   product_t product;

   // Expected product travelling alongside the operands it belongs to
   product_t    stim_exp;
   logic [31:0] lfsr;
   logic [31:0] stim_mem [3*N_DIR];

   product_t exp_q[$];
   int       issue_q[$];
   int       cyc;

   booth_mult_top #(.WIDTH(WIDTH)) u_booth_mult_top (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .multiplier   (multiplier),
      .multiplicand (multiplicand),
      .out_valid    (out_valid),
      .product      (product)
   );

   initial begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic compare_product(input product_t got, input product_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t: product got %h expected %h", $time, got, exp);
         $display("sim failed");
         $fatal(1, "product mismatch");
      end
   endtask

   task automatic compare_valid(input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t: out_valid got %b expected %b", $time, got, exp);
         $display("sim failed");
         $fatal(1, "out_valid mismatch");
      end
   endtask

   task automatic drive_pair(input operand_t a, input operand_t b, input product_t exp);
      @(posedge CLK);
      in_valid     <= 1'b1;
      multiplicand <= a;
      multiplier   <= b;
      stim_exp     <= exp;
   endtask

   task automatic drive_idle(input int n);
      repeat (n) begin
         @(posedge CLK);
         in_valid <= 1'b0;
      end
   endtask

   task automatic drive_random();
      operand_t a;
      operand_t b;
      product_t wa;
      product_t wb;
      a = operand_t'(take_bits(WIDTH));
      b = operand_t'(take_bits(WIDTH));
      wa = product_t'(a);
      wb = product_t'(b);
      drive_pair(a, b, wa * wb);
   endtask

   // Idle cycles after the last result catch any stray out_valid
   task automatic drain();
      drive_idle(1);
      while (issue_q.size() != 0) begin
         @(negedge CLK);
      end
      drive_idle(4);
   endtask

   // Outputs are sampled on the falling edge, half a cycle after they settle.
   // A strobe seen here is taken by the DUT at the next rising edge, and its
   // result is seen LATENCY falling edges later
   always @(negedge CLK) begin
      logic exp_v;
      cyc = cyc + 1;
      if (!rst_n) begin
         exp_q.delete();
         issue_q.delete();
         compare_valid(out_valid, 1'b0);
      end else begin
         exp_v = (issue_q.size() != 0) && (cyc - issue_q[0] == LATENCY);
         compare_valid(out_valid, exp_v);
         if (exp_v) begin
            compare_product(product, exp_q[0]);
            void'(exp_q.pop_front());
            void'(issue_q.pop_front());
         end
         if (in_valid) begin
            exp_q.push_back(stim_exp);
            issue_q.push_back(cyc);
         end
      end
   end

   initial begin
      #(WATCH_CYCLES * CLK_PERIOD);
      $display("Timeout: the run went past %0d cycles without finishing", WATCH_CYCLES);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      rst_n        = 1'b0;
      in_valid     = 1'b0;
      multiplier   = '0;
      multiplicand = '0;
      stim_exp     = '0;
      lfsr         = 32'h8d52_bb11;
      cyc          = 0;
      $readmemh("test/booth_stim.mem", stim_mem);

      repeat (RST_CYCLES) @(posedge CLK);
      rst_n <= 1'b1;

      // Nothing may come out before the first strobe
      drive_idle(IDLE_START);

      for (int i = 0; i < N_DIR; i++) begin
         drive_pair(stim_mem[3*i][WIDTH-1:0], stim_mem[3*i+1][WIDTH-1:0],
                    stim_mem[3*i+2]);
      end
      drain();

      for (int i = 0; i < N_B2B; i++) begin
         drive_random();
      end
      drain();

      for (int i = 0; i < N_GAP; i++) begin
         drive_random();
         drive_idle(int'(take_bits(2)));
      end
      drain();

      // Reset lands while several results are still in the pipeline
      for (int i = 0; i < N_PRE_RST; i++) begin
         drive_random();
      end
      @(posedge CLK);
      in_valid <= 1'b0;
      rst_n    <= 1'b0;
      repeat (RST_CYCLES) @(posedge CLK);
      rst_n <= 1'b1;
      for (int i = 0; i < N_POST_RST; i++) begin
         drive_random();
      end
      drain();

      $display("sim passed");
      $finish;
   end

endmodule

// ==== test/booth_stim.mem ====
// multiplicand multiplier expected_product
// Low nibbles of 00ab vectors walk the lowest digit through -4..+3
0000 0000 00000000
0001 0001 00000001
ffff ffff fffe0001
0000 ffff 00000000
0001 ffff 0000ffff
ffff 0001 0000ffff
1234 0001 00001234
00ab 0002 00000156
00ab 0003 00000201
00ab 0004 000002ac
00ab 0005 00000357
00ab 0006 00000402
00ab 0007 000004ad
8001 001c 000e001c
ffff c000 bfff4000
ffff 8000 7fff8000
1234 4000 048d0000
1000 0038 00038000
aaaa 5555 38e31c72
7fff 7fff 3fff0001
8000 8000 40000000
0003 ffff 0002fffd
00ff 00ff 0000fe01
ffff 0002 0001fffe

// ==== all.f ====
source/booth_pkg.sv
source/booth_if.sv
source/booth_recoder.sv
source/pp_gen.sv
source/csa_tree.sv
source/prefix_adder.sv
source/booth_mult_top.sv
test/tb_booth_mult.sv

// ==== Makefile ====
TOP = tb_booth_mult

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@grep -q "sim passed" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
